// File: Makefile
.PHONY: help test clean

help:
	@echo "test  - build with Verilator and run the testbench"
	@echo "clean - remove build output"

test:
	verilator --binary --assert -j 0 -f filelist.f --top-module dcache_tb -Mdir obj_dir
	@out="$$(./obj_dir/Vdcache_tb)"; echo "$$out"; \
	echo "$$out" | grep -q "^All tests passed$$"

clean:
	rm -rf obj_dir

// File: filelist.f
+incdir+logic
logic/dcache_types_pkg.sv
logic/dcache_ctrl_pkg.sv
logic/dcache_sdpram.sv
logic/dcache_lru.sv
logic/dcache_way_match.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
verif/dcache_checker.sv
verif/dcache_tb.sv

// File: logic/dcache_ctrl.sv
`include "dcache_defines.svh"

module dcache_ctrl (
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                cpu_req_i,
   input  logic                                cpu_we_i,
   input  logic [`DC_OPERAND_WIDTH-1:0]        cpu_adr_i,
   input  logic [`DC_OPERAND_WIDTH-1:0]        wradr_i,
   input  logic                                we_i,
   input  logic                                hit_i,
   input  dcache_types_pkg::dc_way_vec_t       way_hit_i,
   input  dcache_types_pkg::dc_tag_entry_t     tag_entry_i,
   input  dcache_types_pkg::dc_lru_hist_t      next_lru_i,
   input  dcache_types_pkg::dc_way_vec_t       lru_i,
   input  logic                                spr_bus_stb_i,
   input  logic                                spr_bus_we_i,
   input  logic [`DC_SPR_ADDR_WIDTH-1:0]       spr_bus_addr_i,
   input  logic [`DC_OPERAND_WIDTH-1:0]        spr_bus_dat_i,
   output logic                                tag_we_o,
   output dcache_types_pkg::dc_set_t           tag_windex_o,
   output dcache_types_pkg::dc_tag_entry_t     tag_din_o,
   output dcache_types_pkg::dc_way_vec_t       way_we_o,
   output dcache_types_pkg::dc_way_adr_t       way_waddr_o,
   output logic                                way_sel_refill_o,
   output dcache_types_pkg::dc_way_vec_t       lru_access_o,
   output dcache_types_pkg::dc_way_vec_t       refill_way_o,
   output logic                                refill_hit_o,
   output logic                                cpu_ack_o,
   output logic                                refill_req_o,
   output logic                                refill_o,
   output logic                                refill_done_o,
   output logic                                spr_bus_ack_o
);

   import dcache_types_pkg::*;
   import dcache_ctrl_pkg::*;

   localparam int WORDS = 2**(`DC_BLOCK_WIDTH - 2);

   dc_state_t        state;
   logic             read;
   logic             refill;
   logic             invalidate;
   logic             ack_q;
   // One bit per refilled word of the block
   logic [WORDS-1:0] refill_valid;
   // One-hot way being replaced
   dc_way_vec_t      victim;
   // Set entry at the miss with the history already aged for the victim
   dc_tag_entry_t    tag_save;
   dc_set_t          inv_set;
   dc_word_idx_t     cpu_word;
   dc_word_idx_t     wr_word;
   dc_word_idx_t     next_word;
   logic             block_match;
   logic             critical;

   assign read = (state == READ);
   assign refill = (state == REFILL);

   assign cpu_word = cpu_adr_i[`DC_BLOCK_WIDTH-1:2];
   assign wr_word = wradr_i[`DC_BLOCK_WIDTH-1:2];
   assign next_word = wr_word + dc_word_idx_t'(1);
   assign block_match = (wradr_i[`DC_LIMIT_WIDTH-1:`DC_BLOCK_WIDTH] ==
                         cpu_adr_i[`DC_LIMIT_WIDTH-1:`DC_BLOCK_WIDTH]);

   // Strobe carrying the word a pending load waits for
   assign critical = refill && we_i && block_match && (wr_word == cpu_word) &&
                     cpu_req_i && !cpu_we_i;

   // Words wrap in the block, so the last strobe finds its successor filled
   assign refill_done_o = refill && we_i && refill_valid[next_word];
   assign refill_hit_o = refill && block_match && refill_valid[cpu_word];

   assign refill_req_o = (read && cpu_req_i && !hit_i) || refill;
   assign refill_o = refill;
   assign refill_way_o = victim;
   assign cpu_ack_o = ack_q;

   // ********************************************************************
   // SPR invalidate
   // ********************************************************************

   assign invalidate = spr_bus_stb_i && spr_bus_we_i &&
                       ((spr_bus_addr_i == `DC_SPR_DCBIR_ADDR) ||
                        (spr_bus_addr_i == `DC_SPR_DCBFR_ADDR));

   // Only states that actually take the invalidate
   assign spr_bus_ack_o = invalidate && ((state == IDLE) || (state == INVALIDATE));

   // ********************************************************************
   // State machine
   // ********************************************************************

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= IDLE;
         ack_q <= 1'b0;
         refill_valid <= '0;
      end else begin
         ack_q <= 1'b0;
         case (state)
            IDLE: begin
               // Invalidate before a CPU request that was not just acknowledged
               if (invalidate) begin
                  inv_set <= spr_bus_dat_i[WAY_WIDTH-1:`DC_BLOCK_WIDTH];
                  state <= INVALIDATE;
               end else if (cpu_req_i && !ack_q) begin
                  state <= cpu_we_i ? WRITE : READ;
               end
            end

            READ: begin
               if (!cpu_req_i) begin
                  state <= IDLE;
               end else if (hit_i) begin
                  ack_q <= 1'b1;
                  state <= IDLE;
               end else begin
                  // On a miss pick the victim and keep the set entry
                  refill_valid <= '0;
                  victim <= lru_i;
                  tag_save.way <= tag_entry_i.way;
                  tag_save.lru <= next_lru_i;
                  state <= REFILL;
               end
            end

            // Stores are acknowledged on a hit and on a miss
            WRITE: begin
               ack_q <= cpu_req_i;
               state <= IDLE;
            end

            REFILL: begin
               if (critical) begin
                  ack_q <= 1'b1;
               end
               if (we_i) begin
                  refill_valid[wr_word] <= 1'b1;
                  if (refill_done_o) begin
                     state <= IDLE;
                  end
               end
            end

            INVALIDATE: begin
               // Keep the latest set while the master holds the strobe
               if (invalidate) begin
                  inv_set <= spr_bus_dat_i[WAY_WIDTH-1:`DC_BLOCK_WIDTH];
               end else begin
                  state <= IDLE;
               end
            end

            default: begin
               state <= IDLE;
            end
         endcase
      end
   end

   // ********************************************************************
   // Tag and way memory writes
   // ********************************************************************

   assign way_sel_refill_o = refill;
   assign way_waddr_o = refill ? wradr_i[WAY_WIDTH-1:2] : cpu_adr_i[WAY_WIDTH-1:2];

   always_comb begin
      tag_we_o = 1'b0;
      tag_windex_o = cpu_adr_i[WAY_WIDTH-1:`DC_BLOCK_WIDTH];
      tag_din_o = tag_entry_i;
      way_we_o = '0;
      lru_access_o = '0;
      case (state)
         READ: begin
            // A hit ages the other ways and a miss ages the victim for tag_save
            lru_access_o = hit_i ? way_hit_i : lru_i;
            if (cpu_req_i && hit_i) begin
               tag_din_o.lru = next_lru_i;
               tag_we_o = 1'b1;
            end
         end

         WRITE: begin
            lru_access_o = way_hit_i;
            if (cpu_req_i && hit_i) begin
               way_we_o = way_hit_i;
               tag_din_o.lru = next_lru_i;
               tag_we_o = 1'b1;
            end
         end

         REFILL: begin
            tag_windex_o = wradr_i[WAY_WIDTH-1:`DC_BLOCK_WIDTH];
            tag_din_o = tag_save;
            if (we_i) begin
               way_we_o = victim;
               // Victim invalid from the first word and valid again after the last
               for (int w = 0; w < `DC_WAYS; w++) begin
                  if (victim[w]) begin
                     tag_din_o.way[w].valid = refill_done_o;
                     tag_din_o.way[w].tag = wradr_i[`DC_LIMIT_WIDTH-1:WAY_WIDTH];
                  end
               end
               tag_we_o = (refill_valid == '0) || refill_done_o;
            end
         end

         // Whole set cleared
         INVALIDATE: begin
            tag_windex_o = inv_set;
            tag_din_o = '0;
            tag_we_o = 1'b1;
         end

         default: begin
         end
      endcase
   end

endmodule

// File: logic/dcache_ctrl_pkg.sv
package dcache_ctrl_pkg;

   // Controller states, one-hot
   typedef enum logic [4:0] {
      IDLE       = 5'b00001,
      READ       = 5'b00010,
      WRITE      = 5'b00100,
      REFILL     = 5'b01000,
      INVALIDATE = 5'b10000
   } dc_state_t;

endpackage

// File: logic/dcache_defines.svh
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// ********************************************************************
// Cache geometry
// ********************************************************************

// Data word width in bits
`define DC_OPERAND_WIDTH 32

// Log2 of the block size in bytes, four words per block
`define DC_BLOCK_WIDTH 4

// Log2 of the number of sets
`define DC_SET_WIDTH 4

// Associativity
`define DC_WAYS 2

// Number of cached address bits
`define DC_LIMIT_WIDTH 32

// ********************************************************************
// SPR map
// ********************************************************************

`define DC_SPR_ADDR_WIDTH 16

// Block invalidate
`define DC_SPR_DCBIR_ADDR 16'h1803
// Block flush, same as invalidate in a write-through cache
`define DC_SPR_DCBFR_ADDR 16'h1802

`endif

// File: logic/dcache_lru.sv
`include "dcache_defines.svh"

module dcache_lru #(
   parameter int NUMWAYS = `DC_WAYS
) (
   input  dcache_types_pkg::dc_lru_hist_t current_i,
   input  dcache_types_pkg::dc_way_vec_t  access_i,
   output dcache_types_pkg::dc_lru_hist_t update_o,
   output dcache_types_pkg::dc_way_vec_t  lru_pre_o
);

   // ********************************************************************
   // Pairwise order history
   // ********************************************************************
   // One bit per pair (i, j) with i < j, pairs numbered in loop order
   // Bit set means way i was used after way j

   always_comb begin
      int idx;
      idx = 0;
      update_o = current_i;
      lru_pre_o = '1;
      for (int i = 0; i < NUMWAYS; i++) begin
         for (int j = i + 1; j < NUMWAYS; j++) begin
            // The newer way of each pair cannot be the LRU
            if (current_i[idx]) begin
               lru_pre_o[i] = 1'b0;
            end else begin
               lru_pre_o[j] = 1'b0;
            end

            // Accessed way becomes newest against its partner
            if (access_i[i]) begin
               update_o[idx] = 1'b1;
            end else if (access_i[j]) begin
               update_o[idx] = 1'b0;
            end

            idx = idx + 1;
         end
      end
   end

endmodule

// File: logic/dcache_sdpram.sv
module dcache_sdpram #(
   parameter type word_t = logic [31:0],
   parameter int ADDR_WIDTH = 4
) (
   input  logic                  clk,
   input  logic [ADDR_WIDTH-1:0] raddr_i,
   input  logic [ADDR_WIDTH-1:0] waddr_i,
   input  logic                  we_i,
   input  word_t                 din_i,
   output word_t                 dout_o
);

   word_t mem [2**ADDR_WIDTH];

   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[waddr_i] <= din_i;
      end
   end

   // Registered read
   // A write to the address being read shows up on the next cycle
   always_ff @(posedge clk) begin
      if (we_i && (waddr_i == raddr_i)) begin
         dout_o <= din_i;
      end else begin
         dout_o <= mem[raddr_i];
      end
   end

endmodule

// File: logic/dcache_top.sv
`include "dcache_defines.svh"

module dcache_top (
   input  logic                               clk,
   input  logic                               rst,
   // CPU
   input  logic                               cpu_req_i,
   input  logic                               cpu_we_i,
   input  logic [`DC_OPERAND_WIDTH-1:0]       cpu_adr_i,
   input  logic [`DC_OPERAND_WIDTH-1:0]       cpu_dat_i,
   input  logic [`DC_OPERAND_WIDTH/8-1:0]     cpu_bsel_i,
   output logic                               cpu_ack_o,
   output dcache_types_pkg::dc_data_t         cpu_dat_o,
   // Refill
   input  logic                               we_i,
   input  logic [`DC_OPERAND_WIDTH-1:0]       wradr_i,
   input  logic [`DC_OPERAND_WIDTH-1:0]       wrdat_i,
   output logic                               refill_req_o,
   output logic                               refill_o,
   output logic                               refill_done_o,
   // SPR
   input  logic                               spr_bus_stb_i,
   input  logic                               spr_bus_we_i,
   input  logic [`DC_SPR_ADDR_WIDTH-1:0]      spr_bus_addr_i,
   input  logic [`DC_OPERAND_WIDTH-1:0]       spr_bus_dat_i,
   output logic                               spr_bus_ack_o
);

   import dcache_types_pkg::*;

   dc_tag_entry_t tag_dout;
   dc_tag_entry_t tag_din;
   dc_set_t       tag_windex;
   logic          tag_we;
   dc_data_t      way_dout [`DC_WAYS];
   dc_data_t      way_din;
   dc_data_t      merged_dat;
   dc_way_adr_t   way_waddr;
   dc_way_vec_t   way_we;
   dc_way_vec_t   way_hit;
   dc_way_vec_t   lru;
   dc_way_vec_t   lru_access;
   dc_way_vec_t   refill_way;
   dc_lru_hist_t  next_lru;
   logic          way_sel_refill;
   logic          hit;
   logic          refill_hit;

   // ********************************************************************
   // Memories, read from the CPU address every cycle
   // ********************************************************************

   dcache_sdpram #(
      .word_t    (dc_tag_entry_t),
      .ADDR_WIDTH(`DC_SET_WIDTH)
   ) u_tag_ram (
      .clk    (clk),
      .raddr_i(cpu_adr_i[WAY_WIDTH-1:`DC_BLOCK_WIDTH]),
      .waddr_i(tag_windex),
      .we_i   (tag_we),
      .din_i  (tag_din),
      .dout_o (tag_dout)
   );

   // Refill data or merged store data
   assign way_din = way_sel_refill ? wrdat_i : merged_dat;

   for (genvar w = 0; w < `DC_WAYS; w++) begin : gen_way
      dcache_sdpram #(
         .word_t    (dc_data_t),
         .ADDR_WIDTH(WAY_WIDTH - 2)
      ) u_way_ram (
         .clk    (clk),
         .raddr_i(cpu_adr_i[WAY_WIDTH-1:2]),
         .waddr_i(way_waddr),
         .we_i   (way_we[w]),
         .din_i  (way_din),
         .dout_o (way_dout[w])
      );
   end

   dcache_way_match u_match (
      .tag_entry_i (tag_dout),
      .adr_i       (cpu_adr_i),
      .way_dout_i  (way_dout),
      .refill_way_i(refill_way),
      .refill_hit_i(refill_hit),
      .cpu_dat_i   (cpu_dat_i),
      .cpu_bsel_i  (cpu_bsel_i),
      .way_hit_o   (way_hit),
      .hit_o       (hit),
      .rd_dat_o    (cpu_dat_o),
      .merged_dat_o(merged_dat)
   );

   dcache_lru #(
      .NUMWAYS(`DC_WAYS)
   ) u_lru (
      .current_i(tag_dout.lru),
      .access_i (lru_access),
      .update_o (next_lru),
      .lru_pre_o(lru)
   );

   dcache_ctrl u_ctrl (
      .clk             (clk),
      .rst             (rst),
      .cpu_req_i       (cpu_req_i),
      .cpu_we_i        (cpu_we_i),
      .cpu_adr_i       (cpu_adr_i),
      .wradr_i         (wradr_i),
      .we_i            (we_i),
      .hit_i           (hit),
      .way_hit_i       (way_hit),
      .tag_entry_i     (tag_dout),
      .next_lru_i      (next_lru),
      .lru_i           (lru),
      .spr_bus_stb_i   (spr_bus_stb_i),
      .spr_bus_we_i    (spr_bus_we_i),
      .spr_bus_addr_i  (spr_bus_addr_i),
      .spr_bus_dat_i   (spr_bus_dat_i),
      .tag_we_o        (tag_we),
      .tag_windex_o    (tag_windex),
      .tag_din_o       (tag_din),
      .way_we_o        (way_we),
      .way_waddr_o     (way_waddr),
      .way_sel_refill_o(way_sel_refill),
      .lru_access_o    (lru_access),
      .refill_way_o    (refill_way),
      .refill_hit_o    (refill_hit),
      .cpu_ack_o       (cpu_ack_o),
      .refill_req_o    (refill_req_o),
      .refill_o        (refill_o),
      .refill_done_o   (refill_done_o),
      .spr_bus_ack_o   (spr_bus_ack_o)
   );

endmodule

// File: logic/dcache_types_pkg.sv
`include "dcache_defines.svh"

package dcache_types_pkg;

   // Address split: tag | set | word | byte
   localparam int WAY_WIDTH = `DC_SET_WIDTH + `DC_BLOCK_WIDTH;
   localparam int TAG_WIDTH = `DC_LIMIT_WIDTH - WAY_WIDTH;

   // One history bit per pair of ways
   localparam int LRU_WIDTH = `DC_WAYS * (`DC_WAYS - 1) / 2;

   typedef logic [`DC_SET_WIDTH-1:0] dc_set_t;
   typedef logic [TAG_WIDTH-1:0] dc_tag_t;
   typedef logic [`DC_BLOCK_WIDTH-3:0] dc_word_idx_t;

   // Way memory word address, set plus word offset
   typedef logic [WAY_WIDTH-3:0] dc_way_adr_t;

   typedef logic [`DC_OPERAND_WIDTH-1:0] dc_data_t;
   typedef logic [`DC_WAYS-1:0] dc_way_vec_t;
   typedef logic [LRU_WIDTH-1:0] dc_lru_hist_t;

   typedef struct packed {
      logic    valid;
      dc_tag_t tag;
   } dc_tag_way_t;

   // Tag memory word
   // LRU history on top, way 0 in the low bits
   typedef struct packed {
      dc_lru_hist_t                lru;
      dc_tag_way_t [`DC_WAYS-1:0] way;
   } dc_tag_entry_t;

endpackage

// File: logic/dcache_way_match.sv
`include "dcache_defines.svh"

module dcache_way_match (
   input  dcache_types_pkg::dc_tag_entry_t tag_entry_i,
   input  logic [`DC_OPERAND_WIDTH-1:0]    adr_i,
   input  dcache_types_pkg::dc_data_t      way_dout_i [`DC_WAYS],
   input  dcache_types_pkg::dc_way_vec_t   refill_way_i,
   input  logic                            refill_hit_i,
   input  logic [`DC_OPERAND_WIDTH-1:0]    cpu_dat_i,
   input  logic [`DC_OPERAND_WIDTH/8-1:0]  cpu_bsel_i,
   output dcache_types_pkg::dc_way_vec_t   way_hit_o,
   output logic                            hit_o,
   output dcache_types_pkg::dc_data_t      rd_dat_o,
   output dcache_types_pkg::dc_data_t      merged_dat_o
);

   import dcache_types_pkg::*;

   dc_tag_t adr_tag;

   assign adr_tag = adr_i[`DC_LIMIT_WIDTH-1:WAY_WIDTH];

   // Valid way with matching tag
   always_comb begin
      for (int w = 0; w < `DC_WAYS; w++) begin
         way_hit_o[w] = tag_entry_i.way[w].valid && (tag_entry_i.way[w].tag == adr_tag);
      end
   end

   assign hit_o = |way_hit_o;

   // Read data from the hitting way
   // During a refill the victim way holds the word before its tag is valid
   always_comb begin
      rd_dat_o = '0;
      for (int w = 0; w < `DC_WAYS; w++) begin
         if (way_hit_o[w] || (refill_hit_i && refill_way_i[w])) begin
            rd_dat_o = way_dout_i[w];
         end
      end
   end

   // Store data
   // Unselected bytes keep the cached value
   always_comb begin
      for (int b = 0; b < `DC_OPERAND_WIDTH / 8; b++) begin
         if (cpu_bsel_i[b]) begin
            merged_dat_o[8*b +: 8] = cpu_dat_i[8*b +: 8];
         end else begin
            merged_dat_o[8*b +: 8] = rd_dat_o[8*b +: 8];
         end
      end
   end

endmodule

// File: verif/dcache_cases.txt
# op address data bsel refill: R load, W store, I SPR invalidate
# data and bsel apply to stores, refill is 1 when refill_req_o is expected
R 00000104 00000000 f 1
R 00000104 00000000 f 0
R 0000010c 00000000 f 0
W 00000108 11223344 3 0
R 00000108 00000000 f 0
W 00000228 aabbccdd f 0
R 00000228 00000000 f 1
R 00000030 00000000 f 1
R 00001030 00000000 f 1
R 00000030 00000000 f 0
R 00002030 00000000 f 1
R 00000030 00000000 f 0
R 00001030 00000000 f 1
I 00000100 00000000 0 0
R 00000104 00000000 f 1
R 0000010c 00000000 f 0
R 00000108 00000000 f 0

// File: verif/dcache_checker.sv
`include "dcache_defines.svh"

module dcache_checker (
   input logic                          clk,
   input logic                          rst,
   input logic                          cpu_req_i,
   input logic                          cpu_ack_i,
   input logic                          we_i,
   input logic                          refill_i,
   input logic                          refill_done_i,
   input logic                          spr_bus_stb_i,
   input logic                          spr_bus_we_i,
   input logic [`DC_SPR_ADDR_WIDTH-1:0] spr_bus_addr_i,
   input logic                          spr_bus_ack_i
);

   // Word strobes seen in the running refill
   logic [1:0] strobe_cnt;
   logic       inv_write;

   always_ff @(posedge clk) begin
      if (rst || !refill_i) begin
         strobe_cnt <= '0;
      end else if (we_i) begin
         strobe_cnt <= strobe_cnt + 2'd1;
      end
   end

   // Block invalidate or flush write on the SPR bus
   assign inv_write = spr_bus_stb_i && spr_bus_we_i &&
                      ((spr_bus_addr_i == `DC_SPR_DCBIR_ADDR) ||
                       (spr_bus_addr_i == `DC_SPR_DCBFR_ADDR));

   // ********************************************************************
   // Top-level protocol rules
   // ********************************************************************

   // Acknowledge only while the CPU still requests
   ack_needs_req : assert property (@(posedge clk) disable iff (rst)
      cpu_ack_i |-> cpu_req_i)
      else $error("cpu_ack_o high without cpu_req_i");

   // Block end marked on the fourth word strobe of a refill and on no other
   done_on_last_strobe : assert property (@(posedge clk) disable iff (rst)
      (we_i && refill_i) |-> (refill_done_i == (strobe_cnt == 2'd3)))
      else $error("refill_done_o not on the last word strobe of the block");

   // SPR acknowledge exactly while an invalidate write meets a quiet cache
   spr_ack_on_invalidate : assert property (@(posedge clk) disable iff (rst)
      spr_bus_ack_i == (inv_write && !cpu_req_i && !refill_i))
      else $error("spr_bus_ack_o does not follow the invalidate write");

endmodule

bind dcache_top dcache_checker u_checker (
   .clk           (clk),
   .rst           (rst),
   .cpu_req_i     (cpu_req_i),
   .cpu_ack_i     (cpu_ack_o),
   .we_i          (we_i),
   .refill_i      (refill_o),
   .refill_done_i (refill_done_o),
   .spr_bus_stb_i (spr_bus_stb_i),
   .spr_bus_we_i  (spr_bus_we_i),
   .spr_bus_addr_i(spr_bus_addr_i),
   .spr_bus_ack_i (spr_bus_ack_o)
);

// File: verif/dcache_tb.sv
`include "dcache_defines.svh"

module dcache_tb;

   import dcache_types_pkg::*;

   logic        clk;
   logic        rst;
   logic        cpu_req_i;
   logic        cpu_we_i;
   logic [31:0] cpu_adr_i;
   logic [31:0] cpu_dat_i;
   logic [3:0]  cpu_bsel_i;
   logic        cpu_ack_o;
   dc_data_t    cpu_dat_o;
   logic        we_i;
   logic [31:0] wradr_i;
   logic [31:0] wrdat_i;
   logic        refill_req_o;
   logic        refill_o;
   logic        refill_done_o;
   logic        spr_bus_stb_i;
   logic        spr_bus_we_i;
   logic [15:0] spr_bus_addr_i;
   logic [31:0] spr_bus_dat_i;
   logic        spr_bus_ack_o;

   // Case table filled from the case file
   byte         op_q [$];
   logic [31:0] adr_q [$];
   logic [31:0] dat_q [$];
   logic [3:0]  bsel_q [$];
   logic        refill_q [$];

   // Backing memory holding the words written by stores
   logic [31:0] mem_model [logic [31:0]];

   int          cycle_count;
   int          cycle_limit;
   logic        saw_refill;
   logic        refill_busy;

   dcache_top u_dut (.*);

   always #2 clk = ~clk;

   // ********************************************************************
   // Failure reporting and checks
   // ********************************************************************

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Some tests failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         fail_run($sformatf("mismatch at %0t: %s got %h expected %h",
                            $time, name, got, exp));
      end
   endtask

   // Run limit
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_limit != 0 && cycle_count > cycle_limit) begin
         fail_run("Timeout: the run took more cycles than allowed");
      end
   end

   // Any refill request seen during the current operation
   always @(negedge clk) begin
      if (refill_req_o) begin
         saw_refill <= 1'b1;
      end
   end

   // ********************************************************************
   // Memory model
   // ********************************************************************

   function automatic logic [31:0] mem_read(input logic [31:0] adr);
      logic [31:0] a;
      a = {adr[31:2], 2'b00};
      if (mem_model.exists(a)) begin
         return mem_model[a];
      end
      // Initial fill where every address bit reaches the word
      return {a[15:0] ^ a[31:16] ^ 16'h5a5a, a[15:0]};
   endfunction

   task automatic mem_store(input logic [31:0] adr, input logic [31:0] dat,
                            input logic [3:0] bsel);
      logic [31:0] w;
      w = mem_read(adr);
      for (int b = 0; b < 4; b++) begin
         if (bsel[b]) begin
            w[8*b +: 8] = dat[8*b +: 8];
         end
      end
      mem_model[{adr[31:2], 2'b00}] = w;
   endtask

   // ********************************************************************
   // Refill responder serving the critical word first with random gaps
   // ********************************************************************

   task automatic serve_refill();
      logic [31:0] base;
      logic [1:0]  word;
      int          gap;
      base = {cpu_adr_i[31:4], 4'b0000};
      word = cpu_adr_i[3:2];
      refill_busy = 1'b1;
      for (int k = 0; k < 4; k++) begin
         gap = $urandom % 3;
         repeat (gap) begin
            @(posedge clk);
            #1;
            we_i = 1'b0;
         end
         @(posedge clk);
         #1;
         we_i = 1'b1;
         wradr_i = base + {28'd0, word, 2'b00};
         wrdat_i = mem_read(wradr_i);
         @(negedge clk);
         check_value("refill_done_o", {31'd0, refill_done_o}, {31'd0, k == 3});
         check_value("refill_o", {31'd0, refill_o}, 32'd1);
         word = word + 2'd1;
      end
      @(posedge clk);
      #1;
      we_i = 1'b0;
      // Back in IDLE after the last word
      check_value("refill_o", {31'd0, refill_o}, 32'd0);
      refill_busy = 1'b0;
   endtask

   initial begin
      forever begin
         @(negedge clk);
         if (refill_o && !refill_busy) begin
            serve_refill();
         end
      end
   end

   // ********************************************************************
   // Bus operations
   // ********************************************************************

   task automatic cpu_access(input logic we, input logic [31:0] adr,
                             input logic [31:0] dat, input logic [3:0] bsel,
                             output logic [31:0] rdat);
      @(posedge clk);
      #1;
      saw_refill = 1'b0;
      cpu_req_i = 1'b1;
      cpu_we_i = we;
      cpu_adr_i = adr;
      cpu_dat_i = dat;
      cpu_bsel_i = bsel;
      do begin
         @(negedge clk);
      end while (!cpu_ack_o);
      rdat = cpu_dat_o;
      @(posedge clk);
      #1;
      cpu_req_i = 1'b0;
      cpu_we_i = 1'b0;
      // Let a running refill finish the block
      while (refill_busy || refill_o) begin
         @(negedge clk);
      end
   endtask

   task automatic spr_invalidate(input logic [15:0] spr, input logic [31:0] adr);
      @(posedge clk);
      #1;
      spr_bus_stb_i = 1'b1;
      spr_bus_we_i = 1'b1;
      spr_bus_addr_i = spr;
      spr_bus_dat_i = adr;
      do begin
         @(negedge clk);
      end while (!spr_bus_ack_o);
      @(posedge clk);
      #1;
      spr_bus_stb_i = 1'b0;
      spr_bus_we_i = 1'b0;
      // INVALIDATE clears the set on the way back to IDLE
      @(posedge clk);
   endtask

   task automatic read_cases();
      int          fd;
      int          n;
      string       line;
      byte         op;
      logic [31:0] adr;
      logic [31:0] dat;
      logic [3:0]  bsel;
      logic        rf;
      fd = $fopen("verif/dcache_cases.txt", "r");
      if (fd == 0) begin
         fail_run("Could not open the case file verif/dcache_cases.txt");
      end
      while (!$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         if (line.len() > 2 && line.getc(0) != "#") begin
            n = $sscanf(line, "%c %h %h %h %h", op, adr, dat, bsel, rf);
            if (n == 5) begin
               op_q.push_back(op);
               adr_q.push_back(adr);
               dat_q.push_back(dat);
               bsel_q.push_back(bsel);
               refill_q.push_back(rf);
            end
         end
      end
      $fclose(fd);
   endtask

   // ********************************************************************
   // Main sequence
   // ********************************************************************

   initial begin
      logic [31:0] rdat;
      clk = 1'b0;
      rst = 1'b1;
      cpu_req_i = 1'b0;
      cpu_we_i = 1'b0;
      cpu_adr_i = '0;
      cpu_dat_i = '0;
      cpu_bsel_i = '0;
      we_i = 1'b0;
      wradr_i = '0;
      wrdat_i = '0;
      spr_bus_stb_i = 1'b0;
      spr_bus_we_i = 1'b0;
      spr_bus_addr_i = '0;
      spr_bus_dat_i = '0;
      cycle_count = 0;
      cycle_limit = 0;
      saw_refill = 1'b0;
      refill_busy = 1'b0;
      void'($urandom(10));

      read_cases();
      if (op_q.size() == 0) begin
         fail_run("The case file holds no operations");
      end
      cycle_limit = op_q.size() * 40 + 200;

      repeat (3) @(posedge clk);
      #1;
      rst = 1'b0;

      // Invalidate every set and use the flush address on odd sets
      for (int s = 0; s < 16; s++) begin
         spr_invalidate(s[0] ? `DC_SPR_DCBFR_ADDR : `DC_SPR_DCBIR_ADDR, s << 4);
      end

      foreach (op_q[i]) begin
         case (op_q[i])
            "R": begin
               cpu_access(1'b0, adr_q[i], '0, 4'hf, rdat);
               check_value("cpu_dat_o", rdat, mem_read(adr_q[i]));
               check_value("refill_req_o", {31'd0, saw_refill}, {31'd0, refill_q[i]});
            end
            "W": begin
               cpu_access(1'b1, adr_q[i], dat_q[i], bsel_q[i], rdat);
               mem_store(adr_q[i], dat_q[i], bsel_q[i]);
               check_value("refill_req_o", {31'd0, saw_refill}, {31'd0, refill_q[i]});
            end
            "I": begin
               spr_invalidate(`DC_SPR_DCBIR_ADDR, adr_q[i]);
            end
            default: begin
               fail_run($sformatf("Unknown operation in case line %0d", i));
            end
         endcase
      end

      $display("All tests passed");
      $finish;
   end

endmodule
